// File: Bender.yml
package:
  name: rv_exec_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/rv_pkg.sv
      - verilog/rv_regfile.sv
      - verilog/rv_alu.sv
      - verilog/rv_decode.sv
      - verilog/rv_execute.sv
      - verilog/rv_result.sv
      - verilog/rv_exec_core.sv
      - target: simulation
        files:
          - dv/tb_rv_exec_core.sv

// File: build.f
+incdir+include
verilog/rv_pkg.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_exec_core.sv
dv/tb_rv_exec_core.sv

// File: dv/tb_rv_exec_core.sv
`timescale 1ns/1ns
`include "rv_core_config.svh"

module tb_rv_exec_core;
    import rv_pkg::*;

    localparam int IDLE     = 3;   // quiet cycles before the first instruction
    localparam int N_SLOTS  = 400;
    localparam int DRAIN    = 8;
    localparam int N_STEPS  = IDLE + N_SLOTS + DRAIN;
    localparam int WDOG_NS  = (N_STEPS + 2 + 20) * 40;

    logic                clk;
    logic                arst_n_i;
    logic                instr_valid_i;
    logic [`RV_XLEN-1:0] instr_i;
    logic [`RV_XLEN-1:0] pc_i;
    redirect_t           redirect;
    retire_t             commit;

    // expectations for the cycle in progress, indexed by drive step
    retire_t             sched_commit [N_STEPS + 4];
    redirect_t           sched_redir [N_STEPS + 4];
    retire_t             exp_commit;
    redirect_t           exp_redir;

    logic [31:0]         lfsr_q;
    logic [31:0]         mregs [`RV_NUM_REGS];
    logic [31:0]         pc_q;
    logic [31:0]         wrong_pc;
    logic [63:0]         order_cnt;
    int                  squash_left;
    int                  errors;
    int                  n_commit;
    int                  n_redirect;

    rv_exec_core rv_exec_core_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .redirect_o    (redirect),
        .commit_o      (commit)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic value_mismatch(input string name, input logic [63:0] exp_v,
                                  input logic [63:0] act_v);
        errors++;
        $display("FAIL at %0t ns: %s expected %h actual %h", $time, name, exp_v, act_v);
        abort_run();
    endtask

    // integer alu from the isa tables
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sra_v;
        sra_v = $signed(a) >>> b[4:0];
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return sra_v;
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // random instruction, registers limited to x0..x7 for dense hazards
    task automatic gen_instr(output logic [31:0] ins);
        logic [31:0] cls;
        logic [31:0] r;
        logic [31:0] hi;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [6:0]  f7;
        logic [6:0]  bad_op;
        take_bits(4, cls);
        take_bits(12, r);
        take_bits(20, hi);
        rd    = {2'b00, r[2:0]};
        rs1   = {2'b00, r[5:3]};
        rs2   = {2'b00, r[8:6]};
        f3    = r[11:9];
        imm12 = hi[11:0];
        if (f3 == 3'b001) begin
            imm12[11:5] = 7'b0;
        end
        if (f3 == 3'b101) begin
            imm12[11:5] = {1'b0, hi[10], 5'b0}; // srli or srai
        end
        f7 = ((f3 == 3'b000) || (f3 == 3'b101)) ? {1'b0, hi[0], 5'b0} : 7'b0;
        case (hi[1:0])
            2'd0:    bad_op = 7'b0000011; // load
            2'd1:    bad_op = 7'b0100011; // store
            2'd2:    bad_op = 7'b1110011;
            default: bad_op = 7'b0001111;
        endcase
        if (cls[3]) begin
            cls = cls[0] ? 32'd5 : 32'd6; // alu ops most of the time
        end
        case (cls[2:0])
            3'd0:    ins = {hi, rd, 7'b0110111};
            3'd1:    ins = {hi, rd, 7'b0010111};
            3'd2:    ins = {hi, rd, 7'b1101111};
            3'd3:    ins = {hi[11:0], rs1, 3'b000, rd, 7'b1100111};
            3'd4:    ins = {hi[6:0], rs2, rs1, f3, hi[11:7], 7'b1100011};
            3'd5:    ins = {imm12, rs1, f3, rd, 7'b0010011};
            3'd6:    ins = {f7, rs2, rs1, f3, rd, 7'b0110011};
            default: ins = {hi, rd, bad_op};
        endcase
    endtask

    // reference execution in program order, fills the expected schedule
    task automatic model_step(input int k, input logic [31:0] ins, input logic [31:0] pc);
        logic [31:0] rs1v;
        logic [31:0] rs2v;
        logic [31:0] i_imm;
        logic [31:0] u_imm;
        logic [31:0] j_imm;
        logic [31:0] b_imm;
        logic [31:0] res;
        logic [31:0] npc;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic        ok;
        logic        wr;
        logic        taken;
        retire_t     c;
        f3    = ins[14:12];
        rd    = ins[11:7];
        rs1v  = mregs[ins[19:15]];
        rs2v  = mregs[ins[24:20]];
        i_imm = {{20{ins[31]}}, ins[31:20]};
        u_imm = {ins[31:12], 12'b0};
        j_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        b_imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        npc   = pc + 32'd4;
        res   = '0;
        ok    = 1'b1;
        wr    = 1'b1;
        taken = 1'b0;
        case (ins[6:0])
            7'b0110111: res = u_imm;
            7'b0010111: res = pc + u_imm;
            7'b1101111: begin
                res = pc + 32'd4;
                npc = pc + j_imm;
            end
            7'b1100111: begin
                res = pc + 32'd4;
                npc = (rs1v + i_imm) & ~32'd1;
            end
            7'b1100011: begin
                wr = 1'b0;
                case (f3)
                    3'b000:  taken = rs1v == rs2v;
                    3'b001:  taken = rs1v != rs2v;
                    3'b100:  taken = $signed(rs1v) < $signed(rs2v);
                    3'b101:  taken = $signed(rs1v) >= $signed(rs2v);
                    3'b110:  taken = rs1v < rs2v;
                    3'b111:  taken = rs1v >= rs2v;
                    default: ok = 1'b0; // reserved branch funct3
                endcase
                if (taken) begin
                    npc = pc + b_imm;
                end
            end
            7'b0010011: res = alu_model(f3, ins[30] && (f3 == 3'b101), rs1v, i_imm);
            7'b0110011: res = alu_model(f3, ins[30], rs1v, rs2v);
            default: ok = 1'b0;
        endcase
        if (ok) begin
            if (wr && (rd != 5'd0)) begin
                mregs[rd] = res;
            end
            c          = '0;
            c.valid    = 1'b1;
            c.order    = order_cnt;
            c.pc       = pc;
            c.instr    = ins;
            c.rd       = rd;
            c.ld_reg   = wr;
            c.rd_wdata = res;
            c.pc_wdata = npc;
            sched_commit[k + 4] = c;
            order_cnt++;
            n_commit++;
            if (npc != pc + 32'd4) begin
                sched_redir[k + 2].valid  = 1'b1;
                sched_redir[k + 2].target = npc;
                squash_left = 2;
                wrong_pc    = pc + 32'd4;
                n_redirect++;
            end
        end
        pc_q = npc;
    endtask

    // outputs sampled at the edge, expectations set 2 ns after the previous edge
    assert property (@(posedge clk) disable iff (!arst_n_i)
        commit.valid === exp_commit.valid)
        else value_mismatch("commit_o.valid", exp_commit.valid, $sampled(commit.valid));
    assert property (@(posedge clk) disable iff (!arst_n_i)
        exp_commit.valid |-> commit.order === exp_commit.order)
        else value_mismatch("commit_o.order", exp_commit.order, $sampled(commit.order));
    assert property (@(posedge clk) disable iff (!arst_n_i)
        exp_commit.valid |-> commit.pc === exp_commit.pc)
        else value_mismatch("commit_o.pc", exp_commit.pc, $sampled(commit.pc));
    assert property (@(posedge clk) disable iff (!arst_n_i)
        exp_commit.valid |-> commit.instr === exp_commit.instr)
        else value_mismatch("commit_o.instr", exp_commit.instr, $sampled(commit.instr));
    assert property (@(posedge clk) disable iff (!arst_n_i)
        exp_commit.valid |-> commit.ld_reg === exp_commit.ld_reg)
        else value_mismatch("commit_o.ld_reg", exp_commit.ld_reg, $sampled(commit.ld_reg));
    assert property (@(posedge clk) disable iff (!arst_n_i)
        exp_commit.valid && exp_commit.ld_reg |-> commit.rd === exp_commit.rd)
        else value_mismatch("commit_o.rd", exp_commit.rd, $sampled(commit.rd));
    assert property (@(posedge clk) disable iff (!arst_n_i)
        exp_commit.valid && exp_commit.ld_reg |-> commit.rd_wdata === exp_commit.rd_wdata)
        else value_mismatch("commit_o.rd_wdata", exp_commit.rd_wdata,
                            $sampled(commit.rd_wdata));
    assert property (@(posedge clk) disable iff (!arst_n_i)
        exp_commit.valid |-> commit.pc_wdata === exp_commit.pc_wdata)
        else value_mismatch("commit_o.pc_wdata", exp_commit.pc_wdata,
                            $sampled(commit.pc_wdata));
    assert property (@(posedge clk) disable iff (!arst_n_i)
        redirect.valid === exp_redir.valid)
        else value_mismatch("redirect_o.valid", exp_redir.valid, $sampled(redirect.valid));
    assert property (@(posedge clk) disable iff (!arst_n_i)
        exp_redir.valid |-> redirect.target === exp_redir.target)
        else value_mismatch("redirect_o.target", exp_redir.target,
                            $sampled(redirect.target));

    initial begin
        #(WDOG_NS);
        $display("watchdog expired before the instruction stream finished");
        abort_run();
    end

    initial begin
        logic [31:0] vbits;
        logic [31:0] ins;
        logic [31:0] pc_drv;
        clk           = 1'b0;
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        exp_commit    = '0;
        exp_redir     = '0;
        lfsr_q        = 32'h88b8a5cf;
        pc_q          = 32'h0000_1000;
        wrong_pc      = '0;
        order_cnt     = '0;
        squash_left   = 0;
        errors        = 0;
        n_commit      = 0;
        n_redirect    = 0;
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            mregs[i] = '0;
        end
        for (int i = 0; i < N_STEPS + 4; i++) begin
            sched_commit[i] = '0;
            sched_redir[i]  = '0;
        end
        repeat (2) @(posedge clk);
        #2;
        arst_n_i = 1'b1;
        for (int k = 0; k < N_STEPS; k++) begin
            exp_commit = sched_commit[k];
            exp_redir  = sched_redir[k];
            if ((k >= IDLE) && (k < IDLE + N_SLOTS)) begin
                take_bits(3, vbits);
                gen_instr(ins);
                if (squash_left > 0) begin
                    pc_drv   = wrong_pc; // wrong path, dropped by the core
                    wrong_pc = wrong_pc + 32'd4;
                    squash_left--;
                end else begin
                    pc_drv = pc_q;
                    if (vbits[2:0] != 3'd0) begin
                        model_step(k, ins, pc_drv);
                    end
                end
                instr_valid_i = (vbits[2:0] != 3'd0);
                instr_i       = ins;
                pc_i          = pc_drv;
            end else begin
                instr_valid_i = 1'b0;
            end
            @(posedge clk);
            #2;
        end
        if ((n_commit == 0) || (n_redirect == 0)) begin
            $display("stimulus never produced a commit or a redirect");
            errors++;
        end
        if (errors == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

// File: include/rv_core_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// datapath width, fixed at rv32
`define RV_XLEN 32

// register file geometry
`define RV_NUM_REGS 32
`define RV_REG_AW 5

// commit order counter, rvfi style
`define RV_ORDER_W 64

`endif

// File: verilog/rv_alu.sv
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_alu (
    input  rv_pkg::alu_op_e     alu_op_i,
    input  logic [`RV_XLEN-1:0] a_i,
    input  logic [`RV_XLEN-1:0] b_i,
    output logic [`RV_XLEN-1:0] f_o
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0]; // rv32 shift amount
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (alu_op_i)
            alu_add:    f_o = a_i + b_i;
            alu_sub:    f_o = a_i - b_i;
            alu_sll:    f_o = a_i << shamt;
            alu_slt:    f_o = {{(`RV_XLEN-1){1'b0}}, lt_s};
            alu_sltu:   f_o = {{(`RV_XLEN-1){1'b0}}, lt_u};
            alu_xor:    f_o = a_i ^ b_i;
            alu_srl:    f_o = a_i >> shamt;
            alu_sra:    f_o = $unsigned($signed(a_i) >>> shamt);
            alu_or:     f_o = a_i | b_i;
            alu_and:    f_o = a_i & b_i;
            alu_pass_b: f_o = b_i;
            default:    f_o = '0;
        endcase
    end

endmodule

// File: verilog/rv_decode.sv
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_decode (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  instr_valid_i,
    input  logic [`RV_XLEN-1:0]   instr_i,
    input  logic [`RV_XLEN-1:0]   pc_i,
    input  rv_pkg::redirect_t     flush_i,
    output logic [`RV_REG_AW-1:0] ra1_o,
    output logic [`RV_REG_AW-1:0] ra2_o,
    input  logic [`RV_XLEN-1:0]   rd1_i,
    input  logic [`RV_XLEN-1:0]   rd2_i,
    output rv_pkg::decoded_t      dec_o
);
    import rv_pkg::*;

    logic                  in_valid_q;
    logic [`RV_XLEN-1:0]   in_instr_q;
    logic [`RV_XLEN-1:0]   in_pc_q;
    logic [1:0]            hist_ld_q; // [0] one ahead, [1] two ahead
    logic [`RV_REG_AW-1:0] hist_rd_q [2];
    logic [2:0]            funct3;
    logic                  supported;
    decoded_t              dec_d;

    // youngest older writer wins, x0 stays on the register file path
    function automatic rs_src_e src_sel(input logic [`RV_REG_AW-1:0] rs);
        if (rs == '0) begin
            return src_regfile;
        end
        if (hist_ld_q[0] && (hist_rd_q[0] == rs)) begin
            return src_fwd_exe;
        end
        if (hist_ld_q[1] && (hist_rd_q[1] == rs)) begin
            return src_fwd_wb;
        end
        return src_regfile;
    endfunction

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
                                        input logic is_reg);
        case (f3)
            3'b000:  return (alt && is_reg) ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // sample stage, the word on instr_i is dropped during a redirect
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= instr_valid_i && !flush_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        in_instr_q <= instr_i;
        in_pc_q    <= pc_i;
    end

    assign ra1_o  = in_instr_q[19:15];
    assign ra2_o  = in_instr_q[24:20];
    assign funct3 = in_instr_q[14:12];

    always_comb begin
        dec_d          = '0;
        supported      = 1'b1;
        dec_d.pc       = in_pc_q;
        dec_d.instr    = in_instr_q;
        dec_d.opcode   = opcode_e'(in_instr_q[6:0]);
        dec_d.rd       = in_instr_q[11:7];
        dec_d.rs1_data = rd1_i;
        dec_d.rs2_data = rd2_i;
        dec_d.rs1_src  = src_sel(ra1_o);
        dec_d.rs2_src  = src_sel(ra2_o);
        dec_d.alu_op   = alu_add;
        dec_d.cmp_op   = cmp_beq;
        dec_d.a_sel    = a_rs1;
        dec_d.b_sel    = b_imm;
        dec_d.ld_reg   = 1'b1;
        case (dec_d.opcode)
            op_lui: begin
                dec_d.alu_op = alu_pass_b;
                dec_d.imm    = {in_instr_q[31:12], 12'b0};
            end
            op_auipc: begin
                dec_d.a_sel = a_pc;
                dec_d.imm   = {in_instr_q[31:12], 12'b0};
            end
            op_jal: begin
                dec_d.a_sel = a_pc; // alu forms the target
                dec_d.imm   = {{12{in_instr_q[31]}}, in_instr_q[19:12], in_instr_q[20],
                               in_instr_q[30:21], 1'b0};
            end
            op_jalr: dec_d.imm = {{20{in_instr_q[31]}}, in_instr_q[31:20]};
            op_br: begin
                supported    = (funct3 != 3'b010) && (funct3 != 3'b011);
                dec_d.ld_reg = 1'b0;
                dec_d.a_sel  = a_pc;
                dec_d.cmp_op = cmp_op_e'(funct3);
                dec_d.imm    = {{20{in_instr_q[31]}}, in_instr_q[7], in_instr_q[30:25],
                                in_instr_q[11:8], 1'b0};
            end
            op_imm: begin
                dec_d.alu_op = alu_sel(funct3, in_instr_q[30], 1'b0);
                dec_d.imm    = {{20{in_instr_q[31]}}, in_instr_q[31:20]};
            end
            op_reg: begin
                dec_d.alu_op = alu_sel(funct3, in_instr_q[30], 1'b1);
                dec_d.b_sel  = b_rs2;
            end
            default: supported = 1'b0; // bubble
        endcase
        dec_d.valid = in_valid_q && supported && !flush_i.valid;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_o     <= '0;
            hist_ld_q <= '0;
        end else begin
            dec_o     <= dec_d;
            hist_ld_q <= {hist_ld_q[0], dec_d.valid && dec_d.ld_reg};
        end
    end

    always_ff @(posedge clk) begin
        hist_rd_q[0] <= dec_d.rd;
        hist_rd_q[1] <= hist_rd_q[0];
    end

endmodule

// File: verilog/rv_exec_core.sv
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_exec_core (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                instr_valid_i,
    input  logic [`RV_XLEN-1:0] instr_i,
    input  logic [`RV_XLEN-1:0] pc_i,
    output rv_pkg::redirect_t   redirect_o,
    output rv_pkg::retire_t     commit_o
);
    import rv_pkg::*;

    logic [`RV_REG_AW-1:0] rf_ra1;
    logic [`RV_REG_AW-1:0] rf_ra2;
    logic [`RV_XLEN-1:0]   rf_rd1;
    logic [`RV_XLEN-1:0]   rf_rd2;
    logic                  rf_we;
    logic [`RV_REG_AW-1:0] rf_wa;
    logic [`RV_XLEN-1:0]   rf_wd;
    decoded_t              dec;
    retire_t               exe;
    fwd_t                  fwd_exe;
    fwd_t                  fwd_wb;

    rv_regfile regfile_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .ra1_i    (rf_ra1),
        .ra2_i    (rf_ra2),
        .rd1_o    (rf_rd1),
        .rd2_o    (rf_rd2),
        .we_i     (rf_we),
        .wa_i     (rf_wa),
        .wd_i     (rf_wd)
    );

    rv_decode decode_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .flush_i       (redirect_o), // squash the two younger slots
        .ra1_o         (rf_ra1),
        .ra2_o         (rf_ra2),
        .rd1_i         (rf_rd1),
        .rd2_i         (rf_rd2),
        .dec_o         (dec)
    );

    rv_execute execute_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .dec_i      (dec),
        .fwd_exe_i  (fwd_exe),
        .fwd_wb_i   (fwd_wb),
        .redirect_o (redirect_o),
        .exe_o      (exe)
    );

    rv_result result_inst (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .exe_i     (exe),
        .rf_we_o   (rf_we),
        .rf_wa_o   (rf_wa),
        .rf_wd_o   (rf_wd),
        .fwd_exe_o (fwd_exe),
        .fwd_wb_o  (fwd_wb),
        .commit_o  (commit_o)
    );

endmodule

// File: verilog/rv_execute.sv
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_execute (
    input  logic              clk,
    input  logic              arst_n_i,
    input  rv_pkg::decoded_t  dec_i,
    input  rv_pkg::fwd_t      fwd_exe_i,
    input  rv_pkg::fwd_t      fwd_wb_i,
    output rv_pkg::redirect_t redirect_o,
    output rv_pkg::retire_t   exe_o
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_f;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] next_pc;
    logic                br_taken;
    logic                is_jump;
    retire_t             exe_d;

    function automatic logic [`RV_XLEN-1:0] pick(input rs_src_e src,
                                                 input logic [`RV_XLEN-1:0] rf_val,
                                                 input logic [`RV_XLEN-1:0] exe_val,
                                                 input logic [`RV_XLEN-1:0] wb_val);
        case (src)
            src_fwd_exe: return exe_val;
            src_fwd_wb:  return wb_val;
            default:     return rf_val;
        endcase
    endfunction

    assign rs1_val = pick(dec_i.rs1_src, dec_i.rs1_data, fwd_exe_i.data, fwd_wb_i.data);
    assign rs2_val = pick(dec_i.rs2_src, dec_i.rs2_data, fwd_exe_i.data, fwd_wb_i.data);
    assign alu_a   = (dec_i.a_sel == a_pc) ? dec_i.pc : rs1_val;
    assign alu_b   = (dec_i.b_sel == b_imm) ? dec_i.imm : rs2_val;

    rv_alu alu_inst (
        .alu_op_i (dec_i.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .f_o      (alu_f)
    );

    always_comb begin
        case (dec_i.cmp_op)
            cmp_beq:  br_taken = rs1_val == rs2_val;
            cmp_bne:  br_taken = rs1_val != rs2_val;
            cmp_blt:  br_taken = $signed(rs1_val) < $signed(rs2_val);
            cmp_bge:  br_taken = $signed(rs1_val) >= $signed(rs2_val);
            cmp_bltu: br_taken = rs1_val < rs2_val;
            cmp_bgeu: br_taken = rs1_val >= rs2_val;
            default:  br_taken = 1'b0;
        endcase
    end

    assign pc_plus4 = dec_i.pc + `RV_XLEN'd4;
    assign is_jump  = (dec_i.opcode == op_jal) || (dec_i.opcode == op_jalr);

    // alu already holds pc+imm or rs1+imm for control transfers
    always_comb begin
        case (dec_i.opcode)
            op_jal:  next_pc = alu_f;
            op_jalr: next_pc = {alu_f[`RV_XLEN-1:1], 1'b0};
            op_br:   next_pc = br_taken ? alu_f : pc_plus4;
            default: next_pc = pc_plus4;
        endcase
    end

    assign redirect_o.valid  = dec_i.valid && (next_pc != pc_plus4);
    assign redirect_o.target = next_pc;

    always_comb begin
        exe_d          = '0; // order stamped in result
        exe_d.valid    = dec_i.valid;
        exe_d.pc       = dec_i.pc;
        exe_d.instr    = dec_i.instr;
        exe_d.rd       = dec_i.rd;
        exe_d.ld_reg   = dec_i.ld_reg;
        exe_d.rd_wdata = is_jump ? pc_plus4 : alu_f; // link value
        exe_d.pc_wdata = next_pc;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exe_o <= '0;
        end else begin
            exe_o <= exe_d;
        end
    end

endmodule

// File: verilog/rv_pkg.sv
`include "rv_core_config.svh"

package rv_pkg;

    // rv32i major opcodes handled by this slice
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and,
        alu_pass_b // lui
    } alu_op_e;

    // encoded as the branch funct3
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic [1:0] {
        src_regfile = 2'd0, // value read in decode
        src_fwd_exe = 2'd1, // one instruction ahead
        src_fwd_wb  = 2'd2  // two instructions ahead
    } rs_src_e;

    typedef enum logic {a_rs1, a_pc} alu_a_sel_e;
    typedef enum logic {b_rs2, b_imm} alu_b_sel_e;

    typedef struct packed {
        logic                   valid;
        logic [`RV_XLEN-1:0]    pc;
        logic [`RV_XLEN-1:0]    instr;
        opcode_e                opcode;
        logic [`RV_REG_AW-1:0]  rd;
        logic                   ld_reg;
        logic [`RV_XLEN-1:0]    rs1_data;
        logic [`RV_XLEN-1:0]    rs2_data;
        rs_src_e                rs1_src;
        rs_src_e                rs2_src;
        alu_op_e                alu_op;
        cmp_op_e                cmp_op;
        alu_a_sel_e             a_sel;
        alu_b_sel_e             b_sel;
        logic [`RV_XLEN-1:0]    imm;
    } decoded_t;

    // execute to result, also the commit record
    typedef struct packed {
        logic                   valid;
        logic [`RV_ORDER_W-1:0] order;
        logic [`RV_XLEN-1:0]    pc;
        logic [`RV_XLEN-1:0]    instr;
        logic [`RV_REG_AW-1:0]  rd;
        logic                   ld_reg;
        logic [`RV_XLEN-1:0]    rd_wdata;
        logic [`RV_XLEN-1:0]    pc_wdata;
    } retire_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV_XLEN-1:0]    target;
    } redirect_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV_REG_AW-1:0]  rd;
        logic [`RV_XLEN-1:0]    data;
    } fwd_t;

endpackage

// File: verilog/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [`RV_REG_AW-1:0] ra1_i,
    input  logic [`RV_REG_AW-1:0] ra2_i,
    output logic [`RV_XLEN-1:0]   rd1_o,
    output logic [`RV_XLEN-1:0]   rd2_o,
    input  logic                  we_i,
    input  logic [`RV_REG_AW-1:0] wa_i,
    input  logic [`RV_XLEN-1:0]   wd_i
);

    logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1]; // no storage for x0

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wa_i != '0)) begin
            regs[wa_i] <= wd_i;
        end
    end

    // asynchronous read, x0 hard zero
    assign rd1_o = (ra1_i == '0) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : regs[ra2_i];

endmodule

// File: verilog/rv_result.sv
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_result (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  rv_pkg::retire_t       exe_i,
    output logic                  rf_we_o,
    output logic [`RV_REG_AW-1:0] rf_wa_o,
    output logic [`RV_XLEN-1:0]   rf_wd_o,
    output rv_pkg::fwd_t          fwd_exe_o,
    output rv_pkg::fwd_t          fwd_wb_o,
    output rv_pkg::retire_t       commit_o
);

    logic [`RV_ORDER_W-1:0] order_q;
    logic                   wr_en;

    // branches and x0 targets never write
    assign wr_en   = exe_i.valid && exe_i.ld_reg && (exe_i.rd != '0);
    assign rf_we_o = wr_en;
    assign rf_wa_o = exe_i.rd;
    assign rf_wd_o = exe_i.rd_wdata;

    assign fwd_exe_o.valid = wr_en;
    assign fwd_exe_o.rd    = exe_i.rd;
    assign fwd_exe_o.data  = exe_i.rd_wdata;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fwd_wb_o <= '0;
            commit_o <= '0;
            order_q  <= '0;
        end else begin
            fwd_wb_o       <= fwd_exe_o; // covers the read that missed the write
            commit_o       <= exe_i;
            commit_o.order <= order_q;
            if (exe_i.valid) begin
                order_q <= order_q + 1'b1;
            end
        end
    end

endmodule
